// File: flash_id_pkg.sv
// shared flash ID constants and types; all counts are in flash_clk cycles, 16-bit bus only
`default_nettype none

package flash_id_pkg;

    // ******************************
    // bus geometry
    // ******************************
    localparam int ADDR_W = 21;
    localparam int DATA_W = 16;

    // ******************************
    // sequence timing
    // ******************************
    localparam int SETTLE_CYCLES      = 255;  // power-up settle before any pin activity
    localparam int RST_CYCLES         = 3;    // flash reset low time
    localparam int RST_RECOVER_CYCLES = 6;
    localparam int ACCESS_CYCLES      = 4;    // one read or write, phase 0..3
    localparam int TIDA_CYCLES        = 9;    // ID access time after entry

    // software-ID command set
    localparam logic [ADDR_W-1:0] CMD_ADDR_A   = 21'h05555;
    localparam logic [ADDR_W-1:0] CMD_ADDR_B   = 21'h02AAA;
    localparam logic [DATA_W-1:0] CMD_UNLOCK_1 = 16'h00AA;
    localparam logic [DATA_W-1:0] CMD_UNLOCK_2 = 16'h0055;
    localparam logic [DATA_W-1:0] CMD_ID_ENTRY = 16'h0090;
    localparam logic [DATA_W-1:0] CMD_ID_EXIT  = 16'h00F0;
    localparam logic [ADDR_W-1:0] MAN_ID_ADDR  = 21'h00000;
    localparam logic [ADDR_W-1:0] DEV_ID_ADDR  = 21'h00001;

    // sequence steps, in walking order
    typedef enum logic [3:0] {
        IDLE, RESET, RECOVER, WRITE_1, WRITE_2, WRITE_3,
        TIDA, READ_MAN, READ_DEV, WRITE_EXIT, DONE
    } flash_step_e;

    // flash pin bundle, 42 bits
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              ce_n;
        logic              oe_n;
        logic              we_n;
        logic              rst_n;
        logic [DATA_W-1:0] dq_out;
        logic              dq_oe;   // high while we own the data bus
    } flash_bus_t;

endpackage

`default_nettype wire

// File: flash_step_timer.sv
// step timer: load only while the count is 0 or 1, durations up to 511 cycles, holds at zero
`default_nettype none

module flash_step_timer
    import flash_id_pkg::*;
(
    input  logic       flash_clk,
    input  logic       sys_rst_n,
    input  logic       load,        // one-cycle strobe on step entry
    input  logic [8:0] load_count,  // step length in cycles
    output logic       expire,      // last cycle of the step
    output logic [1:0] phase        // access phase 0..3
);

    logic [8:0] count;  // cycles left in current step

    // ******************************
    // down-counter
    // ******************************
    always_ff @(posedge flash_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= load_count;
        end else if (count != '0) begin
            count <= count - 9'd1;  // parks at zero
        end
    end

    // count of 1 means this is the step's final cycle
    assign expire = (count == 9'd1);

    // phase counts up as count runs down from ACCESS_CYCLES
    // only the low two bits matter, so modulo 4 is enough
    assign phase = 2'(ACCESS_CYCLES) - count[1:0];

endmodule

`default_nettype wire

// File: flash_seq_fsm.sv
// ID read sequencer: restart is honoured only in DONE, settle wait runs once per reset
`default_nettype none

module flash_seq_fsm
    import flash_id_pkg::*;
(
    input  logic        flash_clk,
    input  logic        sys_rst_n,
    input  logic        restart,     // strobe, ignored outside DONE
    input  logic        expire,      // from step timer
    output logic        load,
    output logic [8:0]  load_count,
    output flash_step_e step,
    output logic        id_valid
);

    flash_step_e step_nxt;
    logic        first;     // high for one cycle after reset, kicks the settle load

    // ******************************
    // step register
    // ******************************
    always_ff @(posedge flash_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            step  <= IDLE;
            first <= 1'b1;
        end else begin
            step  <= step_nxt;
            first <= 1'b0;
        end
    end

    // next step, every timed step advances on expire
    always_comb begin
        step_nxt = step;
        case (step)
            IDLE:       if (expire)  step_nxt = RESET;
            RESET:      if (expire)  step_nxt = RECOVER;
            RECOVER:    if (expire)  step_nxt = WRITE_1;
            WRITE_1:    if (expire)  step_nxt = WRITE_2;  // AA to 5555
            WRITE_2:    if (expire)  step_nxt = WRITE_3;  // 55 to 2AAA
            WRITE_3:    if (expire)  step_nxt = TIDA;     // 90 to 5555
            TIDA:       if (expire)  step_nxt = READ_MAN;
            READ_MAN:   if (expire)  step_nxt = READ_DEV;
            READ_DEV:   if (expire)  step_nxt = WRITE_EXIT;
            WRITE_EXIT: if (expire)  step_nxt = DONE;     // F0 back to array mode
            DONE:       if (restart) step_nxt = RESET;    // skip settle on rerun
            default:                 step_nxt = IDLE;
        endcase
    end

    // ******************************
    // timer loading
    // ******************************
    // load on every step change so the new duration starts next cycle
    assign load = first | (step_nxt != step);

    always_comb begin
        case (step_nxt)
            IDLE:       load_count = 9'(SETTLE_CYCLES);
            RESET:      load_count = 9'(RST_CYCLES);
            RECOVER:    load_count = 9'(RST_RECOVER_CYCLES);
            TIDA:       load_count = 9'(TIDA_CYCLES);
            WRITE_1, WRITE_2, WRITE_3,
            READ_MAN, READ_DEV,
            WRITE_EXIT: load_count = 9'(ACCESS_CYCLES);
            default:    load_count = 9'd0;  // DONE waits untimed
        endcase
    end

    // both ID words are latched well before DONE
    assign id_valid = (step == DONE);

endmodule

`default_nettype wire

// File: flash_bus_driver.sv
// pin driver: outputs are registered, so pins trail step and phase by one flash_clk cycle
`default_nettype none

module flash_bus_driver
    import flash_id_pkg::*;
(
    input  logic        flash_clk,
    input  logic        sys_rst_n,
    input  flash_step_e step,
    input  logic [1:0]  phase,
    output flash_bus_t  bus
);

    logic              is_write;
    logic              is_read;
    logic [ADDR_W-1:0] addr_nxt;
    logic [DATA_W-1:0] data_nxt;

    // ******************************
    // step decode
    // ******************************
    always_comb begin
        is_write = 1'b0;
        is_read  = 1'b0;
        addr_nxt = '0;
        data_nxt = '0;
        case (step)
            WRITE_1: begin
                is_write = 1'b1;
                addr_nxt = CMD_ADDR_A;
                data_nxt = CMD_UNLOCK_1;
            end
            WRITE_2: begin
                is_write = 1'b1;
                addr_nxt = CMD_ADDR_B;
                data_nxt = CMD_UNLOCK_2;
            end
            WRITE_3: begin
                is_write = 1'b1;
                addr_nxt = CMD_ADDR_A;
                data_nxt = CMD_ID_ENTRY;
            end
            WRITE_EXIT: begin
                is_write = 1'b1;
                addr_nxt = CMD_ADDR_A;
                data_nxt = CMD_ID_EXIT;
            end
            READ_MAN: begin is_read = 1'b1; addr_nxt = MAN_ID_ADDR; end
            READ_DEV: begin is_read = 1'b1; addr_nxt = DEV_ID_ADDR; end
            default: ;  // bus idle
        endcase
    end

    // ******************************
    // pin registers
    // ******************************
    always_ff @(posedge flash_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            bus <= '{addr: '0, ce_n: 1'b1, oe_n: 1'b1, we_n: 1'b1, rst_n: 1'b1,
                     dq_out: '0, dq_oe: 1'b0};
        end else begin
            bus.addr   <= addr_nxt;                         // held for whole access
            bus.ce_n   <= ~(is_write | is_read);
            bus.oe_n   <= ~is_read;
            bus.we_n   <= ~(is_write & (phase == 2'd1));    // single low cycle, mid access
            bus.rst_n  <= (step != RESET);
            bus.dq_out <= data_nxt;
            bus.dq_oe  <= is_write & ~is_read;              // never drive while oe_n low
        end
    end

endmodule

`default_nettype wire

// File: flash_id_capture.sv
// ID capture: flash must drive valid data within two cycles of oe_n falling
`default_nettype none

module flash_id_capture
    import flash_id_pkg::*;
(
    input  logic              flash_clk,
    input  logic              sys_rst_n,
    input  flash_step_e       step,
    input  logic [1:0]        phase,
    input  logic [DATA_W-1:0] dq_in,
    output logic [DATA_W-1:0] man_id,
    output logic [DATA_W-1:0] dev_id
);

    logic sample;   // mid-read strobe

    // phase 2 is the second pin cycle with oe_n low
    assign sample = (phase == 2'd2);

    // ******************************
    // identifier registers
    // ******************************
    // kept across restart, only overwritten by the next read
    always_ff @(posedge flash_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            man_id <= '0;
            dev_id <= '0;
        end else if (sample) begin
            if (step == READ_MAN) man_id <= dq_in;
            if (step == READ_DEV) dev_id <= dq_in;
        end
    end

endmodule

`default_nettype wire

// File: flash_id_top.sv
// NOR flash ID reader top: data bus split into out, enable and in, tristate resolved outside
`default_nettype none

module flash_id_top
    import flash_id_pkg::*;
(
    input  logic              flash_clk,
    input  logic              sys_rst_n,
    input  logic              restart,      // rerun the sequence, DONE only
    input  logic [DATA_W-1:0] dq_in,
    output logic [ADDR_W-1:0] flash_addr,
    output logic              flash_ce_n,
    output logic              flash_oe_n,
    output logic              flash_we_n,
    output logic              flash_rst_n,
    output logic [DATA_W-1:0] dq_out,
    output logic              dq_oe,
    output logic [DATA_W-1:0] man_id,
    output logic [DATA_W-1:0] dev_id,
    output logic              id_valid,
    output logic [7:0]        led
);

    logic        load;
    logic [8:0]  load_count;
    logic        expire;
    logic [1:0]  phase;
    flash_step_e step;
    flash_bus_t  bus;

    // ******************************
    // sequencing and timing
    // ******************************
    flash_step_timer u_timer (
        .flash_clk (flash_clk), .sys_rst_n (sys_rst_n),
        .load      (load),      .load_count (load_count),
        .expire    (expire),    .phase      (phase)
    );

    flash_seq_fsm u_fsm (
        .flash_clk  (flash_clk),  .sys_rst_n (sys_rst_n),
        .restart    (restart),    .expire    (expire),
        .load       (load),       .load_count (load_count),
        .step       (step),       .id_valid  (id_valid)
    );

    // ******************************
    // pins and capture
    // ******************************
    flash_bus_driver u_driver (
        .flash_clk (flash_clk), .sys_rst_n (sys_rst_n),
        .step      (step),      .phase     (phase),
        .bus       (bus)
    );

    flash_id_capture u_capture (
        .flash_clk (flash_clk), .sys_rst_n (sys_rst_n),
        .step      (step),      .phase     (phase),
        .dq_in     (dq_in),
        .man_id    (man_id),    .dev_id    (dev_id)
    );

    // unpack bus onto the pins
    assign flash_addr  = bus.addr;
    assign flash_ce_n  = bus.ce_n;
    assign flash_oe_n  = bus.oe_n;
    assign flash_we_n  = bus.we_n;
    assign flash_rst_n = bus.rst_n;
    assign dq_out      = bus.dq_out;
    assign dq_oe       = bus.dq_oe;

    assign led = dev_id[7:0];   // device ID low byte on the board LEDs

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
// testbench clock and reset: period 40 time units, reset low across the first two rising edges
`default_nettype none

module tb_clk_gen (
    output logic flash_clk,
    output logic sys_rst_n
);

    initial begin
        flash_clk = 1'b0;
        forever #20 flash_clk = ~flash_clk;     // half period
    end

    initial begin
        sys_rst_n = 1'b1;                        // short high so the flops see a falling edge
        #1 sys_rst_n = 1'b0;
        repeat (2) @(posedge flash_clk);
        #5 sys_rst_n = 1'b1;                     // released off the edge, like other inputs
    end

endmodule

`default_nettype wire

// File: tb_flash_model.sv
// behavioral NOR flash in ID mode after AA 55 90 until F0, no program or erase, rising edge only
`default_nettype none

module tb_flash_model
    import flash_id_pkg::*;
(
    input  logic              flash_clk,
    input  logic [ADDR_W-1:0] addr,
    input  logic              ce_n,
    input  logic              oe_n,
    input  logic              we_n,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] dq_out,
    input  logic              dq_oe,
    input  logic [DATA_W-1:0] man_cfg,     // identifiers to answer with
    input  logic [DATA_W-1:0] dev_cfg,
    output logic [DATA_W-1:0] dq_in,
    output logic              exit_seen = 1'b0,   // F0 written since the last entry
    output logic              proto_err = 1'b0
);

    logic              id_mode = 1'b0;
    logic              recover_chk = 1'b0;   // first access after a reset pulse pending
    logic              prev_ce_n = 1'b1;
    logic              prev_oe_n = 1'b1;
    logic              prev_we_n = 1'b1;
    logic [ADDR_W-1:0] prev_addr = '0;
    logic [DATA_W-1:0] prev_dq = '0;
    int                wr_idx = 0;           // position in the command list
    int                rd_idx = 0;
    int                cyc = 0;
    int                ce_run = 0;           // samples in the current ce_n low run
    int                rst_low = 0;
    int                t_rst = 0;
    int                t_entry = 0;

    // command list of one run with entry then exit
    function automatic logic [ADDR_W+DATA_W-1:0] expected_write(input int idx);
        case (idx)
            0:       return {21'h05555, 16'h00AA};
            1:       return {21'h02AAA, 16'h0055};
            2:       return {21'h05555, 16'h0090};
            default: return {21'h05555, 16'h00F0};
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        proto_err = 1'b1;
    endtask

    // resolved bus is pulled up when nobody drives it
    assign dq_in = dq_oe ? dq_out
                 : (ce_n || oe_n) ? '1
                 : (id_mode && addr == 21'd0) ? man_cfg
                 : (id_mode && addr == 21'd1) ? dev_cfg
                 : addr[DATA_W-1:0];                    // array data mirrors the address

    // mode flips on write samples only and never on a read sample
    always @(posedge flash_clk) begin
        cyc = cyc + 1;
        assert (!(dq_oe && !oe_n)) else report_error("dq_oe high while oe_n low");
        assert (ce_n == 1'b0 || (we_n && oe_n && !dq_oe))
            else report_error("control without ce_n");
        if (!rst_n) begin
            rst_low = rst_low + 1;
            id_mode = 1'b0;                             // reset returns to array mode
            wr_idx  = 0;
        end else if (rst_low != 0) begin
            assert (rst_low == RST_CYCLES) else report_error("rst_n low time wrong");
            rst_low     = 0;
            t_rst       = cyc;
            recover_chk = 1'b1;
        end
        // ******************************
        // access framing in a ce_n run
        // ******************************
        if (!ce_n) begin
            if (prev_ce_n && recover_chk) begin
                assert (cyc - t_rst >= RST_RECOVER_CYCLES)
                    else report_error("access in recovery");
                recover_chk = 1'b0;
            end
            if (ce_run % ACCESS_CYCLES != 0) begin
                assert (addr == prev_addr && dq_out == prev_dq)
                    else report_error("bus moved mid access");
            end
            assert (we_n || ce_run % ACCESS_CYCLES == 1)
                else report_error("we_n low off phase 1");
            ce_run = ce_run + 1;
        end else if (!prev_ce_n) begin
            assert (ce_run == 3 * ACCESS_CYCLES) else report_error("ce_n run not three accesses");
            ce_run = 0;
        end
        if (!we_n) begin                                // command word taken while we_n low
            assert (dq_oe && prev_we_n && wr_idx < 4) else report_error("bad write strobe");
            assert ({addr, dq_out} == expected_write(wr_idx)) else report_error("wrong command");
            if (dq_out == 16'h0090) begin
                id_mode   = 1'b1;
                exit_seen = 1'b0;
                t_entry   = cyc;
                rd_idx    = 0;
            end else if (dq_out == 16'h00F0) begin
                id_mode   = 1'b0;
                exit_seen = 1'b1;
            end
            wr_idx = wr_idx + 1;
        end
        // t_entry marks phase 1 of the entry write, which ends two cycles later
        if (!oe_n && (prev_oe_n || addr != prev_addr)) begin   // new read access
            assert (id_mode && addr == 21'(rd_idx)
                    && cyc - t_entry >= TIDA_CYCLES + ACCESS_CYCLES - 1)
                else report_error("read out of order or too early");
            rd_idx = rd_idx + 1;
        end
        prev_ce_n = ce_n;
        prev_oe_n = oe_n;
        prev_we_n = we_n;
        prev_addr = addr;
        prev_dq   = dq_out;
    end

endmodule

`default_nettype wire

// File: tb_flash_id.sv
// testbench top runs one ID read after reset and then a restart with fresh LFSR identifiers
`default_nettype none

module tb_flash_id
    import flash_id_pkg::*;
();

    // settle plus the bus steps with some margin
    // the rerun skips the settle wait
    localparam int SEQ_CYCLES     = SETTLE_CYCLES + RST_CYCLES + RST_RECOVER_CYCLES
                                  + TIDA_CYCLES + 6 * ACCESS_CYCLES + 20;
    localparam int TIMEOUT_CYCLES = 3 * SEQ_CYCLES;

    logic              flash_clk;
    logic              sys_rst_n;
    logic              restart;
    logic [ADDR_W-1:0] flash_addr;
    logic              flash_ce_n, flash_oe_n, flash_we_n, flash_rst_n;
    logic [DATA_W-1:0] dq_in, dq_out, man_id, dev_id;
    logic              dq_oe, id_valid;
    logic [7:0]        led;
    logic [DATA_W-1:0] man_cfg, dev_cfg;      // what the flash model answers
    logic              exit_seen, proto_err;
    logic [15:0]       lfsr = 16'd57157;
    int                cycles = 0;

    tb_clk_gen u_clk (.flash_clk (flash_clk), .sys_rst_n (sys_rst_n));

    flash_id_top flash_id_top_i (
        .flash_clk  (flash_clk),  .sys_rst_n   (sys_rst_n),   .restart    (restart),
        .dq_in      (dq_in),      .flash_addr  (flash_addr),  .flash_ce_n (flash_ce_n),
        .flash_oe_n (flash_oe_n), .flash_we_n  (flash_we_n),  .flash_rst_n (flash_rst_n),
        .dq_out     (dq_out),     .dq_oe       (dq_oe),       .man_id     (man_id),
        .dev_id     (dev_id),     .id_valid    (id_valid),    .led        (led)
    );

    tb_flash_model u_flash (
        .flash_clk (flash_clk),  .addr (flash_addr), .ce_n (flash_ce_n), .oe_n (flash_oe_n),
        .we_n      (flash_we_n), .rst_n (flash_rst_n), .dq_out (dq_out), .dq_oe (dq_oe),
        .man_cfg   (man_cfg),    .dev_cfg (dev_cfg), .dq_in (dq_in),
        .exit_seen (exit_seen),  .proto_err (proto_err)
    );

    // Galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_word(output logic [DATA_W-1:0] w);
        w = '0;
        for (int i = 0; i < DATA_W; i++) begin
            lfsr = lfsr_next(lfsr);                 // one step per bit taken
            w    = {w[DATA_W-2:0], lfsr[0]};
        end
    endtask

    function automatic logic pins_idle();
        return flash_ce_n && flash_oe_n && flash_we_n && flash_rst_n && !dq_oe && !id_valid
            && man_id == '0 && dev_id == '0;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic check_ids(input logic [DATA_W-1:0] exp_man,
                             input logic [DATA_W-1:0] exp_dev);
        while (!id_valid) begin
            @(posedge flash_clk);
            #5;
        end
        assert (man_id == exp_man && dev_id == exp_dev) else fail_run($sformatf(
            "FAIL %0t: ids %h/%h, expected %h/%h", $time, man_id, dev_id, exp_man, exp_dev));
        assert (led == exp_dev[7:0]) else fail_run($sformatf("FAIL %0t: led %h", $time, led));
        assert (exit_seen) else fail_run("id_valid rose before the F0 exit write");
    endtask

    // ******************************
    // watchdogs
    // ******************************
    always @(posedge flash_clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) fail_run("timeout, the ID sequence never finished");
    end

    always @(posedge proto_err) fail_run("flash model saw a bus protocol error");

    initial begin
        restart = 1'b0;
        draw_word(man_cfg);
        draw_word(dev_cfg);
        @(posedge flash_clk);
        #5;
        assert (!sys_rst_n && pins_idle()) else fail_run("outputs active during reset");
        wait (sys_rst_n);
        repeat (SETTLE_CYCLES) begin                // no pin moves while settling
            @(posedge flash_clk);
            #5;
            assert (pins_idle())
                else fail_run($sformatf("FAIL %0t: pins active in settle", $time));
        end
        check_ids(man_cfg, dev_cfg);
        // ******************************
        // restart with new identifiers
        // ******************************
        draw_word(man_cfg);
        draw_word(dev_cfg);
        restart = 1'b1;
        @(posedge flash_clk);
        #5;
        restart = 1'b0;
        assert (!id_valid) else fail_run("id_valid still high after restart");
        @(posedge flash_clk);
        #5;
        assert (!flash_rst_n) else fail_run("restart did not go straight to the flash reset");
        check_ids(man_cfg, dev_cfg);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: flash_id.f
flash_id_pkg.sv
flash_step_timer.sv
flash_seq_fsm.sv
flash_bus_driver.sv
flash_id_capture.sv
flash_id_top.sv
tb_clk_gen.sv
tb_flash_model.sv
tb_flash_id.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench; the exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_flash_id -f flash_id.f -o tb_flash_id
./obj_dir/tb_flash_id
